/* list.f */
+incdir+src
src/cpu_types_pkg.sv
src/pipe_ctrl_pkg.sv
src/register_file.sv
src/alu.sv
src/control_unit.sv
src/forward_unit.sv
src/hazard_unit.sv
src/datapath.sv
testbench/memory_model.sv
testbench/datapath_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f list.f --top-module datapath_tb \
	-o sim_datapath &&
./obj_dir/sim_datapath | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* src/alu.sv */
// arithmetic and logic unit
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu import cpu_types_pkg::*; (
	input logic [`WORD_W-1:0] a,
	input logic [`WORD_W-1:0] b,
	input aluop_t op,
	output logic [`WORD_W-1:0] result,
	output logic zero,
	output logic negative,
	output logic overflow
);
	localparam int MSB = `WORD_W - 1;

	logic [`WORD_W-1:0] sum;
	logic [`WORD_W-1:0] diff;
	logic add_ovf;
	logic sub_ovf;

	assign sum = a + b;
	assign diff = a - b;
	// sign of the result disagrees with what the operands allow
	assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
	assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum;
				overflow = add_ovf;
			end
			ALU_SUB: begin
				result = diff;
				overflow = sub_ovf;
			end
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			// signed less-than, corrected for overflow
			ALU_SLT: result = {{MSB{1'b0}}, diff[MSB] ^ sub_ovf};
			ALU_SLL: result = a << b[4:0];
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);
	assign negative = result[MSB];

endmodule

/* src/control_unit.sv */
// instruction decoder
`timescale 1ns/1ps
`include "cpu_defines.svh"

module control_unit import cpu_types_pkg::*, pipe_ctrl_pkg::*; (
	input instr_u instr,
	output aluop_t aluop,
	output alusrc_t alusrc,
	output wbsel_t wbsel,
	output pcsel_t pcsel,
	output logic regwrite,
	output logic dmemren,
	output logic dmemwen,
	output logic sign_ext,
	output logic branch_ne,
	output logic halt_op,
	output logic dest_rd,
	output logic link
);
	always_comb begin
		// unknown encodings fall through as a no-op
		aluop = ALU_ADD;
		alusrc = SRC_REG;
		wbsel = WB_ALU;
		pcsel = PC_NEXT;
		regwrite = 1'b0;
		dmemren = 1'b0;
		dmemwen = 1'b0;
		sign_ext = 1'b0;
		branch_ne = 1'b0;
		halt_op = 1'b0;
		dest_rd = 1'b0;
		link = 1'b0;
		case (instr.r_view.opcode)
			OP_RTYPE: begin
				regwrite = 1'b1;
				dest_rd = 1'b1;
				case (instr.r_view.funct)
					F_ADDU: aluop = ALU_ADD;
					F_SUBU: aluop = ALU_SUB;
					F_AND: aluop = ALU_AND;
					F_OR: aluop = ALU_OR;
					F_SLT: aluop = ALU_SLT;
					F_SLL: begin
						aluop = ALU_SLL;
						alusrc = SRC_SHAMT;
					end
					F_JR: begin
						regwrite = 1'b0;
						pcsel = PC_JR;
					end
					default: regwrite = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				regwrite = 1'b1;
				alusrc = SRC_IMM;
				sign_ext = 1'b1;
			end
			OP_ORI: begin
				regwrite = 1'b1;
				alusrc = SRC_IMM;
				aluop = ALU_OR;
			end
			OP_LUI: begin
				regwrite = 1'b1;
				alusrc = SRC_IMM;
				aluop = ALU_LUI;
				wbsel = WB_UPPER;
			end
			OP_LW: begin
				regwrite = 1'b1;
				alusrc = SRC_IMM;
				sign_ext = 1'b1;
				dmemren = 1'b1;
				wbsel = WB_LOAD;
			end
			OP_SW: begin
				alusrc = SRC_IMM;
				sign_ext = 1'b1;
				dmemwen = 1'b1;
			end
			// compare by subtraction, offset is signed
			OP_BEQ, OP_BNE: begin
				aluop = ALU_SUB;
				pcsel = PC_BRANCH;
				sign_ext = 1'b1;
				branch_ne = (instr.r_view.opcode == OP_BNE);
			end
			OP_J: pcsel = PC_JUMP;
			OP_JAL: begin
				pcsel = PC_JUMP;
				regwrite = 1'b1;
				wbsel = WB_LINK;
				link = 1'b1;
			end
			OP_HALT: halt_op = (instr == `HALT_WORD);
			default: ;
		endcase
	end

	always_comb begin
		assert final (!(dmemren && dmemwen))
			else $error("decoder requests read and write together");
	end

endmodule

/* src/cpu_defines.svh */
// processor width constants
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and register index widths
`define WORD_W 32
`define REG_AW 5

// reset vector
`define PC_INIT 32'h0000_0000

// the whole word is the halt instruction, not just its opcode
`define HALT_WORD 32'hffff_ffff

`endif

/* src/cpu_types_pkg.sv */
// instruction set types
`include "cpu_defines.svh"

package cpu_types_pkg;

	// major opcodes of the subset
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J = 6'h02,
		OP_JAL = 6'h03,
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI = 6'h0d,
		OP_LUI = 6'h0f,
		OP_LW = 6'h23,
		OP_SW = 6'h2b,
		OP_HALT = 6'h3f
	} opcode_t;

	// r-type function codes
	typedef enum logic [5:0] {
		F_SLL = 6'h00,
		F_JR = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND = 6'h24,
		F_OR = 6'h25,
		F_SLT = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluop_t;

	typedef struct packed {
		opcode_t opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] shamt;
		funct_t funct;
	} r_view_t;

	typedef struct packed {
		opcode_t opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [15:0] imm16;
	} i_view_t;

	// one fetched word, seen as r-type or i-type
	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} instr_u;

endpackage

/* src/datapath.sv */
// five stage pipelined mips core
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath import cpu_types_pkg::*, pipe_ctrl_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic [`WORD_W-1:0] imemload,
	input logic ihit,
	input logic [`WORD_W-1:0] dmemload,
	input logic dhit,
	output logic imemren,
	output logic [`WORD_W-1:0] imemaddr,
	output logic dmemren,
	output logic dmemwen,
	output logic [`WORD_W-1:0] dmemaddr,
	output logic [`WORD_W-1:0] dmemstore,
	output logic halt
);
	// fetch and IF/ID
	logic [`WORD_W-1:0] pc, pc_plus4;
	logic if_id_valid;
	instr_u if_id_instr;
	logic [`WORD_W-1:0] if_id_npc;

	// decode
	aluop_t id_aluop;
	alusrc_t id_alusrc;
	wbsel_t id_wbsel;
	pcsel_t id_pcsel;
	logic id_regwrite, id_dmemren, id_dmemwen, id_sign_ext;
	logic id_branch_ne, id_halt, id_dest_rd, id_link;
	logic [`WORD_W-1:0] id_rdat1, id_rdat2, id_imm;
	logic [`REG_AW-1:0] id_dest;

	// ID/EX
	logic id_ex_valid;
	aluop_t id_ex_aluop;
	alusrc_t id_ex_alusrc;
	wbsel_t id_ex_wbsel;
	pcsel_t id_ex_pcsel;
	logic id_ex_regwrite, id_ex_dmemren, id_ex_dmemwen, id_ex_branch_ne, id_ex_halt;
	logic [`WORD_W-1:0] id_ex_rdat1, id_ex_rdat2, id_ex_imm, id_ex_npc;
	logic [`REG_AW-1:0] id_ex_shamt, id_ex_rs, id_ex_rt, id_ex_dest;
	logic [25:0] id_ex_jaddr;

	// execute
	fwd_t fwd_a, fwd_b;
	logic [`WORD_W-1:0] ex_rs_val, ex_rt_val, alu_a, alu_b, alu_out;
	logic [`WORD_W-1:0] ex_result, ex_target;
	logic alu_zero;

	// EX/MEM
	logic ex_mem_valid;
	wbsel_t ex_mem_wbsel;
	pcsel_t ex_mem_pcsel;
	logic ex_mem_regwrite, ex_mem_dmemren, ex_mem_dmemwen;
	logic ex_mem_branch_ne, ex_mem_halt, ex_mem_zero;
	logic [`WORD_W-1:0] ex_mem_result, ex_mem_store, ex_mem_target;
	logic [`REG_AW-1:0] ex_mem_dest;
	logic redirect, mem_halt;

	// MEM/WB and writeback
	logic mem_wb_valid, mem_wb_regwrite;
	wbsel_t mem_wb_wbsel;
	logic [`WORD_W-1:0] mem_wb_result, mem_wb_load, wb_data;
	logic [`REG_AW-1:0] mem_wb_dest;
	logic wb_write;

	// hazard controls
	logic pc_wen, if_id_wen, id_ex_wen, ex_mem_wen, mem_wb_wen;
	logic if_id_flush, id_ex_flush, ex_mem_flush;

	function automatic logic [`WORD_W-1:0] fwd_mux(input fwd_t sel,
			input logic [`WORD_W-1:0] reg_val, input logic [`WORD_W-1:0] mem_val,
			input logic [`WORD_W-1:0] wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign imemren = 1'b1;
	assign imemaddr = pc;
	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pc <= `PC_INIT;
		end else if (pc_wen) begin
			pc <= redirect ? ex_mem_target : pc_plus4;
		end
	end

	// latch valid bits, payload below only matters while valid
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			if_id_valid <= 1'b0;
			id_ex_valid <= 1'b0;
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
		end else begin
			if (if_id_flush)
				if_id_valid <= 1'b0;
			else if (if_id_wen)
				if_id_valid <= 1'b1;
			if (id_ex_flush)
				id_ex_valid <= 1'b0;
			else if (id_ex_wen)
				id_ex_valid <= if_id_valid;
			if (ex_mem_flush)
				ex_mem_valid <= 1'b0;
			else if (ex_mem_wen)
				ex_mem_valid <= id_ex_valid;
			if (mem_wb_wen)
				mem_wb_valid <= ex_mem_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (if_id_wen) begin
			if_id_instr <= imemload;
			if_id_npc <= pc_plus4;
		end
	end

	control_unit ctrl0 (
		.instr(if_id_instr),
		.aluop(id_aluop),
		.alusrc(id_alusrc),
		.wbsel(id_wbsel),
		.pcsel(id_pcsel),
		.regwrite(id_regwrite),
		.dmemren(id_dmemren),
		.dmemwen(id_dmemwen),
		.sign_ext(id_sign_ext),
		.branch_ne(id_branch_ne),
		.halt_op(id_halt),
		.dest_rd(id_dest_rd),
		.link(id_link)
	);

	register_file rf0 (
		.CLK(CLK),
		.nRST(nRST),
		.wen(wb_write),
		.wsel(mem_wb_dest),
		.wdat(wb_data),
		.rsel1(if_id_instr.r_view.rs),
		.rsel2(if_id_instr.r_view.rt),
		.rdat1(id_rdat1),
		.rdat2(id_rdat2)
	);

	assign id_imm = id_sign_ext ? {{16{if_id_instr.i_view.imm16[15]}}, if_id_instr.i_view.imm16}
		: {16'h0000, if_id_instr.i_view.imm16};
	// jal links into r31
	assign id_dest = id_link ? 5'd31
		: (id_dest_rd ? if_id_instr.r_view.rd : if_id_instr.r_view.rt);

	always_ff @(posedge CLK) begin
		if (id_ex_wen) begin
			id_ex_aluop <= id_aluop;
			id_ex_alusrc <= id_alusrc;
			id_ex_wbsel <= id_wbsel;
			id_ex_pcsel <= id_pcsel;
			id_ex_regwrite <= id_regwrite;
			id_ex_dmemren <= id_dmemren;
			id_ex_dmemwen <= id_dmemwen;
			id_ex_branch_ne <= id_branch_ne;
			id_ex_halt <= id_halt;
			id_ex_rdat1 <= id_rdat1;
			id_ex_rdat2 <= id_rdat2;
			id_ex_imm <= id_imm;
			id_ex_npc <= if_id_npc;
			id_ex_shamt <= if_id_instr.r_view.shamt;
			id_ex_rs <= if_id_instr.r_view.rs;
			id_ex_rt <= if_id_instr.r_view.rt;
			id_ex_dest <= id_dest;
			// jump field is the low 26 bits of the word
			id_ex_jaddr <= {if_id_instr.r_view.rs, if_id_instr.r_view.rt, if_id_instr.r_view.rd,
				if_id_instr.r_view.shamt, if_id_instr.r_view.funct};
		end
	end

	forward_unit fwd0 (
		.ex_rs(id_ex_rs),
		.ex_rt(id_ex_rt),
		.mem_dest(ex_mem_dest),
		.wb_dest(mem_wb_dest),
		.mem_regwrite(ex_mem_valid && ex_mem_regwrite),
		.wb_regwrite(wb_write),
		.mem_wbsel(ex_mem_wbsel),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	assign ex_rs_val = fwd_mux(fwd_a, id_ex_rdat1, ex_mem_result, wb_data);
	assign ex_rt_val = fwd_mux(fwd_b, id_ex_rdat2, ex_mem_result, wb_data);

	// sll shifts rt, so rt moves onto the a side
	assign alu_a = (id_ex_alusrc == SRC_SHAMT) ? ex_rt_val : ex_rs_val;

	always_comb begin
		case (id_ex_alusrc)
			SRC_IMM: alu_b = id_ex_imm;
			SRC_SHAMT: alu_b = {{(`WORD_W - `REG_AW){1'b0}}, id_ex_shamt};
			default: alu_b = ex_rt_val;
		endcase
	end

	alu alu0 (
		.a(alu_a),
		.b(alu_b),
		.op(id_ex_aluop),
		.result(alu_out),
		.zero(alu_zero),
		.negative(),
		.overflow()
	);

	assign ex_result = (id_ex_wbsel == WB_LINK) ? id_ex_npc : alu_out;

	always_comb begin
		case (id_ex_pcsel)
			PC_BRANCH: ex_target = id_ex_npc + {id_ex_imm[`WORD_W-3:0], 2'b00};
			PC_JUMP: ex_target = {id_ex_npc[31:28], id_ex_jaddr, 2'b00};
			PC_JR: ex_target = ex_rs_val;
			default: ex_target = id_ex_npc;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (ex_mem_wen) begin
			ex_mem_wbsel <= id_ex_wbsel;
			ex_mem_pcsel <= id_ex_pcsel;
			ex_mem_regwrite <= id_ex_regwrite;
			ex_mem_dmemren <= id_ex_dmemren;
			ex_mem_dmemwen <= id_ex_dmemwen;
			ex_mem_branch_ne <= id_ex_branch_ne;
			ex_mem_halt <= id_ex_halt;
			ex_mem_zero <= alu_zero;
			ex_mem_result <= ex_result;
			ex_mem_store <= ex_rt_val;
			ex_mem_target <= ex_target;
			ex_mem_dest <= id_ex_dest;
		end
	end

	assign dmemren = ex_mem_valid && ex_mem_dmemren;
	assign dmemwen = ex_mem_valid && ex_mem_dmemwen;
	assign dmemaddr = ex_mem_result;
	assign dmemstore = ex_mem_store;
	assign mem_halt = ex_mem_valid && ex_mem_halt;

	// branches and jumps resolve here in MEM
	assign redirect = ex_mem_valid && (ex_mem_pcsel == PC_JUMP || ex_mem_pcsel == PC_JR
		|| (ex_mem_pcsel == PC_BRANCH && (ex_mem_zero ^ ex_mem_branch_ne)));

	// sticky once the halt word leaves MEM
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halt <= 1'b0;
		end else if (mem_halt) begin
			halt <= 1'b1;
		end
	end

	hazard_unit haz0 (
		.ihit(ihit),
		.dhit(dhit),
		.mem_dmem_req(dmemren || dmemwen),
		.redirect(redirect),
		.ex_dmemren(id_ex_valid && id_ex_dmemren),
		.ex_rt(id_ex_rt),
		.id_rs(if_id_instr.r_view.rs),
		.id_rt(if_id_instr.r_view.rt),
		.halted(halt || mem_halt),
		.pc_wen(pc_wen),
		.if_id_wen(if_id_wen),
		.id_ex_wen(id_ex_wen),
		.ex_mem_wen(ex_mem_wen),
		.mem_wb_wen(mem_wb_wen),
		.if_id_flush(if_id_flush),
		.id_ex_flush(id_ex_flush),
		.ex_mem_flush(ex_mem_flush)
	);

	always_ff @(posedge CLK) begin
		if (mem_wb_wen) begin
			mem_wb_regwrite <= ex_mem_regwrite;
			mem_wb_wbsel <= ex_mem_wbsel;
			mem_wb_result <= ex_mem_result;
			mem_wb_load <= dmemload;
			mem_wb_dest <= ex_mem_dest;
		end
	end

	assign wb_write = mem_wb_valid && mem_wb_regwrite;
	assign wb_data = (mem_wb_wbsel == WB_LOAD) ? mem_wb_load : mem_wb_result;

	assert property (@(posedge CLK) disable iff (!nRST) imemaddr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

/* src/forward_unit.sv */
// execute stage operand forwarding
`timescale 1ns/1ps

module forward_unit import pipe_ctrl_pkg::*; (
	input logic [4:0] ex_rs,
	input logic [4:0] ex_rt,
	input logic [4:0] mem_dest,
	input logic [4:0] wb_dest,
	input logic mem_regwrite,
	input logic wb_regwrite,
	input wbsel_t mem_wbsel,
	output fwd_t fwd_a,
	output fwd_t fwd_b
);
	logic mem_ok;
	logic wb_ok;

	// a load still in MEM has no data, the hazard unit stalls for it
	assign mem_ok = mem_regwrite && (mem_dest != '0) && (mem_wbsel != WB_LOAD);
	assign wb_ok = wb_regwrite && (wb_dest != '0);

	// younger producer in EX/MEM wins over MEM/WB
	function automatic fwd_t pick(input logic [4:0] src, input logic m_ok,
			input logic [4:0] m_dest, input logic w_ok, input logic [4:0] w_dest);
		if (m_ok && m_dest == src)
			return FWD_MEM;
		if (w_ok && w_dest == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	assign fwd_a = pick(ex_rs, mem_ok, mem_dest, wb_ok, wb_dest);
	assign fwd_b = pick(ex_rt, mem_ok, mem_dest, wb_ok, wb_dest);

endmodule

/* src/hazard_unit.sv */
// pipeline stall and flush control
`timescale 1ns/1ps

module hazard_unit (
	input logic ihit,
	input logic dhit,
	input logic mem_dmem_req,
	input logic redirect,
	input logic ex_dmemren,
	input logic [4:0] ex_rt,
	input logic [4:0] id_rs,
	input logic [4:0] id_rt,
	input logic halted,
	output logic pc_wen,
	output logic if_id_wen,
	output logic id_ex_wen,
	output logic ex_mem_wen,
	output logic mem_wb_wen,
	output logic if_id_flush,
	output logic id_ex_flush,
	output logic ex_mem_flush
);
	logic dwait;
	logic load_use;

	assign dwait = mem_dmem_req && !dhit;
	assign load_use = ex_dmemren && (ex_rt != '0) && (ex_rt == id_rs || ex_rt == id_rt);

	always_comb begin
		pc_wen = 1'b1;
		if_id_wen = 1'b1;
		id_ex_wen = 1'b1;
		ex_mem_wen = 1'b1;
		mem_wb_wen = 1'b1;
		if_id_flush = 1'b0;
		id_ex_flush = 1'b0;
		ex_mem_flush = 1'b0;
		if (dwait || (redirect && !ihit)) begin
			// freeze everything; a redirect also waits so the fetch address stays put
			pc_wen = 1'b0;
			if_id_wen = 1'b0;
			id_ex_wen = 1'b0;
			ex_mem_wen = 1'b0;
			mem_wb_wen = 1'b0;
		end else if (halted || redirect) begin
			// halt drains to writeback, younger work is discarded
			pc_wen = !halted;
			if_id_flush = 1'b1;
			id_ex_flush = 1'b1;
			ex_mem_flush = 1'b1;
		end else if (load_use) begin
			pc_wen = 1'b0;
			if_id_wen = 1'b0;
			id_ex_flush = 1'b1;
		end else if (!ihit) begin
			pc_wen = 1'b0;
			if_id_flush = 1'b1;
		end
	end

	always_comb begin
		assert final (!(if_id_flush && !if_id_wen) && !(id_ex_flush && !id_ex_wen)
				&& !(ex_mem_flush && !ex_mem_wen))
			else $error("latch flushed and held together");
	end

endmodule

/* src/pipe_ctrl_pkg.sv */
// pipeline control types
package pipe_ctrl_pkg;

	// next pc source
	typedef enum logic [1:0] {
		PC_NEXT,
		PC_BRANCH,
		PC_JUMP,
		PC_JR
	} pcsel_t;

	// register write data source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_UPPER,
		WB_LINK
	} wbsel_t;

	// alu b operand source
	typedef enum logic [1:0] {
		SRC_REG,
		SRC_IMM,
		SRC_SHAMT
	} alusrc_t;

	// execute operand forwarding
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_t;

endpackage

/* src/register_file.sv */
// mips register file
`timescale 1ns/1ps
`include "cpu_defines.svh"

module register_file (
	input logic CLK,
	input logic nRST,
	input logic wen,
	input logic [`REG_AW-1:0] wsel,
	input logic [`WORD_W-1:0] wdat,
	input logic [`REG_AW-1:0] rsel1,
	input logic [`REG_AW-1:0] rsel2,
	output logic [`WORD_W-1:0] rdat1,
	output logic [`WORD_W-1:0] rdat2
);
	logic [`WORD_W-1:0] regs [1 << `REG_AW];
	logic write_live;

	// r0 is never written, so it stays at its reset value
	assign write_live = wen && (wsel != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			regs <= '{default: '0};
		end else if (write_live) begin
			regs[wsel] <= wdat;
		end
	end

	// write-first, decode sees the value written back this cycle
	assign rdat1 = (write_live && wsel == rsel1) ? wdat : regs[rsel1];
	assign rdat2 = (write_live && wsel == rsel2) ? wdat : regs[rsel2];

	assert property (@(posedge CLK) disable iff (!nRST) wen |-> !$isunknown(wsel))
		else $error("register write with unknown wsel");

endmodule

/* testbench/datapath_tb.sv */
// pipelined core testbench
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath_tb;
	localparam int N_STORES = 13;
	localparam int WATCHDOG_CYCLES = 4000;
	localparam logic [31:0] POISON_ADDR = 32'h0000_03f0;

	logic CLK;
	logic nRST;
	logic [31:0] imemload;
	logic ihit;
	logic [31:0] dmemload;
	logic dhit;
	logic imemren;
	logic [31:0] imemaddr;
	logic dmemren;
	logic dmemwen;
	logic [31:0] dmemaddr;
	logic [31:0] dmemstore;
	logic halt;

	logic [31:0] exp_addr [N_STORES];
	logic [31:0] exp_data [N_STORES];
	int store_idx;
	logic store_done;

	datapath dut0 (
		.CLK(CLK),
		.nRST(nRST),
		.imemload(imemload),
		.ihit(ihit),
		.dmemload(dmemload),
		.dhit(dhit),
		.imemren(imemren),
		.imemaddr(imemaddr),
		.dmemren(dmemren),
		.dmemwen(dmemwen),
		.dmemaddr(dmemaddr),
		.dmemstore(dmemstore),
		.halt(halt)
	);

	memory_model #(.SEED(32'h89ca_050e)) mem0 (
		.CLK(CLK),
		.nRST(nRST),
		.imemren(imemren),
		.imemaddr(imemaddr),
		.dmemren(dmemren),
		.dmemwen(dmemwen),
		.dmemaddr(dmemaddr),
		.dmemstore(dmemstore),
		.imemload(imemload),
		.ihit(ihit),
		.dmemload(dmemload),
		.dhit(dhit)
	);

	always #20 CLK = ~CLK;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		stop_on_error($sformatf("[ERROR] %s expected %h got %h", name, expected, actual));
	endtask

	// instruction encoders
	function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
			input int shamt, input logic [5:0] funct);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
			input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input int word_index);
		return {op, word_index[25:0]};
	endfunction

	task automatic load_program();
		logic [31:0] prog [45];
		prog[0] = enc_i(6'h09, 0, 20, 16'h0100);
		prog[1] = enc_i(6'h09, 0, 21, 16'h03f0);
		// dependent alu chain where each step forwards from the one before
		prog[2] = enc_i(6'h09, 0, 1, 16'd5);
		prog[3] = enc_i(6'h09, 1, 2, 16'd10);
		prog[4] = enc_r(1, 2, 3, 0, 6'h21);
		prog[5] = enc_r(3, 1, 4, 0, 6'h23);
		prog[6] = enc_r(4, 3, 5, 0, 6'h24);
		prog[7] = enc_r(5, 1, 6, 0, 6'h25);
		prog[8] = enc_i(6'h09, 0, 8, 16'hfffd);
		prog[9] = enc_r(8, 6, 7, 0, 6'h2a);
		prog[10] = enc_r(0, 3, 9, 4, 6'h00);
		prog[11] = enc_i(6'h0f, 0, 10, 16'h1234);
		prog[12] = enc_i(6'h0d, 10, 10, 16'h5678);
		prog[13] = enc_i(6'h2b, 20, 10, 16'd28);
		prog[14] = enc_i(6'h2b, 20, 2, 16'd0);
		prog[15] = enc_i(6'h2b, 20, 3, 16'd4);
		prog[16] = enc_i(6'h2b, 20, 4, 16'd8);
		prog[17] = enc_i(6'h2b, 20, 5, 16'd12);
		prog[18] = enc_i(6'h2b, 20, 6, 16'd16);
		prog[19] = enc_i(6'h2b, 20, 7, 16'd20);
		prog[20] = enc_i(6'h2b, 20, 9, 16'd24);
		// load-use pair
		prog[21] = enc_i(6'h23, 20, 11, 16'd28);
		prog[22] = enc_r(11, 1, 12, 0, 6'h21);
		prog[23] = enc_i(6'h2b, 20, 12, 16'd32);
		// beq taken over two poison stores
		prog[24] = enc_i(6'h04, 2, 4, 16'd2);
		prog[25] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[26] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[27] = enc_i(6'h05, 2, 4, 16'd1);
		prog[28] = enc_i(6'h2b, 20, 5, 16'd36);
		prog[29] = enc_i(6'h04, 1, 2, 16'd1);
		prog[30] = enc_i(6'h2b, 20, 6, 16'd40);
		// jumps with a subroutine at 38 that returns to 35
		prog[31] = enc_j(6'h02, 34);
		prog[32] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[33] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[34] = enc_j(6'h03, 38);
		prog[35] = enc_i(6'h2b, 20, 31, 16'd44);
		prog[36] = enc_j(6'h02, 41);
		prog[37] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[38] = enc_r(31, 0, 0, 0, 6'h08);
		prog[39] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[40] = enc_i(6'h2b, 21, 1, 16'd0);
		prog[41] = enc_i(6'h09, 0, 0, 16'd77);
		prog[42] = enc_i(6'h2b, 20, 0, 16'd48);
		prog[43] = `HALT_WORD;
		prog[44] = enc_i(6'h2b, 21, 1, 16'd0);
		for (int i = 0; i < 256; i++) begin
			mem0.imem[i] = (i < 45) ? prog[i] : `HALT_WORD;
			mem0.dmem[i] = 32'hbad0_0000 | (i << 2);
		end
	endtask

	task automatic set_expected(input int idx, input logic [31:0] addr, input logic [31:0] data);
		exp_addr[idx] = addr;
		exp_data[idx] = data;
	endtask

	// results worked out by hand from the program above
	task automatic build_expected();
		set_expected(0, 32'h0000_011c, 32'h1234_5678);
		set_expected(1, 32'h0000_0100, 32'd15);
		set_expected(2, 32'h0000_0104, 32'd20);
		set_expected(3, 32'h0000_0108, 32'd15);
		set_expected(4, 32'h0000_010c, 32'd4);
		set_expected(5, 32'h0000_0110, 32'd5);
		set_expected(6, 32'h0000_0114, 32'd1);
		set_expected(7, 32'h0000_0118, 32'h0000_0140);
		set_expected(8, 32'h0000_0120, 32'h1234_567d);
		set_expected(9, 32'h0000_0124, 32'd4);
		set_expected(10, 32'h0000_0128, 32'd5);
		// link of jal at 0x88
		set_expected(11, 32'h0000_012c, 32'h0000_008c);
		set_expected(12, 32'h0000_0130, 32'd0);
	endtask

	assign store_done = dmemwen && dhit;

	always @(posedge CLK) begin
		if (!nRST)
			store_idx <= 0;
		else if (store_done)
			store_idx <= store_idx + 1;
	end

	assert property (@(posedge CLK) disable iff (!nRST) store_done |-> store_idx < N_STORES)
		else stop_on_error("more stores completed than the program makes");

	assert property (@(posedge CLK) disable iff (!nRST)
			store_done && store_idx < N_STORES |-> dmemaddr == exp_addr[store_idx])
		else report_mismatch("dmemaddr", exp_addr[$sampled(store_idx)], $sampled(dmemaddr));

	assert property (@(posedge CLK) disable iff (!nRST)
			store_done && store_idx < N_STORES |-> dmemstore == exp_data[store_idx])
		else report_mismatch("dmemstore", exp_data[$sampled(store_idx)], $sampled(dmemstore));

	assert property (@(posedge CLK) disable iff (!nRST) dmemwen |-> dmemaddr != POISON_ADDR)
		else stop_on_error("a store from a skipped path reached the poison address");

	// pending request must hold still
	assert property (@(posedge CLK) disable iff (!nRST)
			(dmemren || dmemwen) && !dhit |=> $stable(dmemaddr) && $stable(dmemstore))
		else stop_on_error("data address or store data moved while waiting for dhit");

	// fetch is always requested once out of reset
	assert property (@(posedge CLK) disable iff (!nRST) imemren)
		else stop_on_error("instruction fetch request dropped after reset");

	assert property (@(posedge CLK) disable iff (!nRST)
			imemren && !ihit |=> $stable(imemaddr))
		else stop_on_error("fetch address moved while waiting for ihit");

	assert property (@(posedge CLK) disable iff (!nRST) halt |=> $stable(imemaddr))
		else stop_on_error("fetch address moved after halt");

	assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
		else stop_on_error("halt dropped after it was raised");

	assert property (@(posedge CLK) disable iff (!nRST) halt |-> !dmemwen && !dmemren)
		else stop_on_error("data request issued after halt");

	assert property (@(posedge CLK) disable iff (!nRST) $rose(halt) |-> store_idx == N_STORES)
		else stop_on_error("halt raised before every expected store was seen");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		stop_on_error($sformatf("timeout, no halt within %0d cycles", WATCHDOG_CYCLES));
	end

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		load_program();
		build_expected();
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		wait (halt === 1'b1);
		// let the halt assertions see a few more cycles
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		if (store_idx == N_STORES) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			stop_on_error($sformatf("only %0d of %0d stores seen", store_idx, N_STORES));
		end
	end

endmodule

/* testbench/memory_model.sv */
// cache handshake memory model
`timescale 1ns/1ps

module memory_model #(
	parameter logic [31:0] SEED = 32'h0000_0001
) (
	input logic CLK,
	input logic nRST,
	input logic imemren,
	input logic [31:0] imemaddr,
	input logic dmemren,
	input logic dmemwen,
	input logic [31:0] dmemaddr,
	input logic [31:0] dmemstore,
	output logic [31:0] imemload,
	output logic ihit,
	output logic [31:0] dmemload,
	output logic dhit
);
	// word arrays that the testbench fills before reset ends
	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] lfsr;
	logic [1:0] iwait;
	logic [1:0] dwait;

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit and two bits for 0 to 3 wait cycles
	task automatic draw_wait(output logic [1:0] w);
		lfsr = lfsr_step(lfsr);
		w[0] = lfsr[0];
		lfsr = lfsr_step(lfsr);
		w[1] = lfsr[0];
	endtask

	initial begin
		lfsr = SEED;
		ihit = 1'b0;
		dhit = 1'b0;
		imemload = '0;
		dmemload = '0;
		iwait = 2'd0;
		dwait = 2'd0;
	end

	// hits change on the falling edge and the core samples them on the rising edge
	always @(negedge CLK) begin
		if (!nRST) begin
			ihit = 1'b0;
			dhit = 1'b0;
		end else begin
			if (ihit) begin
				ihit = 1'b0;
				draw_wait(iwait);
			end else if (imemren) begin
				if (iwait == 2'd0) begin
					ihit = 1'b1;
					imemload = imem[imemaddr[9:2]];
				end else begin
					iwait = iwait - 2'd1;
				end
			end
			if (dhit) begin
				dhit = 1'b0;
				draw_wait(dwait);
			end else if (dmemren || dmemwen) begin
				if (dwait == 2'd0) begin
					dhit = 1'b1;
					dmemload = dmem[dmemaddr[9:2]];
				end else begin
					dwait = dwait - 2'd1;
				end
			end
		end
	end

	// store lands on the edge that completes the transfer
	always @(posedge CLK) begin
		if (dhit && dmemwen)
			dmem[dmemaddr[9:2]] = dmemstore;
	end

endmodule
